/* rtl/mmc_bb_pkg.sv */
`default_nettype none

package mmc_bb_pkg;

  // ***************************************************************************
  // Register map
  // ***************************************************************************
  localparam logic [2:0] REG_DAT_O    = 3'd0;
  localparam logic [2:0] REG_DAT_I    = 3'd1;
  localparam logic [2:0] REG_CMD_O    = 3'd2;
  localparam logic [2:0] REG_CMD_I    = 3'd3;
  localparam logic [2:0] REG_OENS     = 3'd4;
  localparam logic [2:0] REG_STATUS   = 3'd5;
  localparam logic [2:0] REG_ADV_TYPE = 3'd6;
  localparam logic [2:0] REG_ADV_MAN  = 3'd7;

  // Card data bus, register and pulse counter width
  localparam int DATA_W = 8;

  // Which access fires an advance
  // Codes 5 to 7 fall back to manual
  typedef enum logic [2:0] {
    ADV_MANUAL = 3'd0,
    ADV_CMD_RD = 3'd1,
    ADV_CMD_WR = 3'd2,
    ADV_DAT_RD = 3'd3,
    ADV_DAT_WR = 3'd4
  } adv_type_e;

  // ***************************************************************************
  // Reset values
  // ***************************************************************************
  localparam logic [DATA_W-1:0] RST_DAT_O = 8'hFF;
  localparam logic              RST_CMD_O = 1'b1;
  localparam logic              RST_IDENT = 1'b1;

  // ***************************************************************************
  // Card clock divider
  // ***************************************************************************
  // Last counter value of one pulse
  localparam logic [DATA_W-1:0] FAST_LAST  = 8'd3;
  localparam logic [DATA_W-1:0] IDENT_LAST = 8'd255;

endpackage

`default_nettype wire

/* rtl/mmc_bb_pin_if.sv */
`default_nettype none

// Synchronized card inputs, pin stage to register stage
interface mmc_bb_pin_if;

  logic                          cmd;
  logic [mmc_bb_pkg::DATA_W-1:0] data;
  logic                          cdetect;
  logic                          wp;

  modport sync (
    output cmd,
    output data,
    output cdetect,
    output wp
  );

  modport regs (
    input cmd,
    input data,
    input cdetect,
    input wp
  );

endinterface

`default_nettype wire

/* rtl/mmc_bb_ctrl_if.sv */
`default_nettype none

// Advance request and pulse status between decode and clock stages
interface mmc_bb_ctrl_if;

  logic advance;     // one-cycle strobe
  logic ident_mode;  // slow identification rate
  logic trans_done;  // no pulse running
  logic card_clk;

  modport dec (
    output advance,
    output ident_mode,
    input  trans_done
  );

  modport gen (
    input  advance,
    input  ident_mode,
    output trans_done,
    output card_clk
  );

endinterface

`default_nettype wire

/* rtl/mmc_bb_pin_sync.sv */
`default_nettype none

module mmc_bb_pin_sync (
  input  wire                          wb_clk_i,
  input  wire                          wb_rst_i,
  input  wire                          mmc_cmd_i,
  input  wire [mmc_bb_pkg::DATA_W-1:0] mmc_data_i,
  input  wire                          mmc_cdetect_i,
  input  wire                          mmc_wp_i,
  mmc_bb_pin_if.sync                   pins
);

  // All card inputs side by side: wp, cdetect, data, cmd
  logic [mmc_bb_pkg::DATA_W+2:0] pin_raw;
  logic [mmc_bb_pkg::DATA_W+2:0] pin_meta_q;
  logic [mmc_bb_pkg::DATA_W+2:0] pin_sync_q;

  assign pin_raw = {mmc_wp_i, mmc_cdetect_i, mmc_data_i, mmc_cmd_i};

  // Two flop synchronizer
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      pin_meta_q <= '0;
      pin_sync_q <= '0;
    end else begin
      pin_meta_q <= pin_raw;
      pin_sync_q <= pin_meta_q;
    end
  end

  // Split back into the pin interface
  assign pins.cmd     = pin_sync_q[0];
  assign pins.data    = pin_sync_q[mmc_bb_pkg::DATA_W:1];
  assign pins.cdetect = pin_sync_q[mmc_bb_pkg::DATA_W+1];
  assign pins.wp      = pin_sync_q[mmc_bb_pkg::DATA_W+2];

endmodule

`default_nettype wire

/* rtl/mmc_bb_regs.sv */
`default_nettype none

module mmc_bb_regs (
  input  wire                           wb_clk_i,
  input  wire                           wb_rst_i,
  input  wire                           wb_stb_i,
  input  wire                           wb_cyc_i,
  input  wire                           wb_we_i,
  input  wire  [2:0]                    wb_adr_i,
  input  wire  [mmc_bb_pkg::DATA_W-1:0] wb_dat_i,
  output logic [mmc_bb_pkg::DATA_W-1:0] wb_dat_o,
  output logic                          wb_ack_o,
  output logic                          mmc_cmd_o,
  output logic                          mmc_cmd_oen_o,
  output logic                          mmc_data_oen_o,
  output logic [mmc_bb_pkg::DATA_W-1:0] mmc_data_o,
  mmc_bb_pin_if.regs                    pins,
  mmc_bb_ctrl_if.dec                    ctrl
);

  logic                          wb_acc;
  logic                          wr_acc;
  logic                          rd_acc;
  logic [mmc_bb_pkg::DATA_W-1:0] rd_data;
  logic                          auto_adv;
  logic                          adv_req;
  logic                          adv_q;
  logic                          ident_q;
  mmc_bb_pkg::adv_type_e         adv_type_q;

  assign wb_acc = wb_stb_i & wb_cyc_i;
  assign wr_acc = wb_acc & wb_we_i;
  assign rd_acc = wb_acc & ~wb_we_i;

  // ***************************************************************************
  // Register writes
  // ***************************************************************************
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      mmc_data_o     <= mmc_bb_pkg::RST_DAT_O;
      mmc_cmd_o      <= mmc_bb_pkg::RST_CMD_O;
      mmc_cmd_oen_o  <= 1'b0;
      mmc_data_oen_o <= 1'b0;
      ident_q        <= mmc_bb_pkg::RST_IDENT;
      adv_type_q     <= mmc_bb_pkg::ADV_MANUAL;
    end else if (wr_acc) begin
      // Read-only addresses fall through
      case (wb_adr_i)
        mmc_bb_pkg::REG_DAT_O: mmc_data_o <= wb_dat_i;
        mmc_bb_pkg::REG_CMD_O: mmc_cmd_o  <= wb_dat_i[0];
        mmc_bb_pkg::REG_OENS: begin
          mmc_cmd_oen_o  <= wb_dat_i[0];
          mmc_data_oen_o <= wb_dat_i[1];
          ident_q        <= wb_dat_i[4];
        end
        mmc_bb_pkg::REG_ADV_TYPE: begin
          adv_type_q <= mmc_bb_pkg::adv_type_e'(wb_dat_i[2:0]);
        end
        default: ;
      endcase
    end
  end

  // ***************************************************************************
  // Read mux
  // ***************************************************************************
  always_comb begin
    case (wb_adr_i)
      mmc_bb_pkg::REG_DAT_O:    rd_data = mmc_data_o;
      mmc_bb_pkg::REG_DAT_I:    rd_data = pins.data;
      mmc_bb_pkg::REG_CMD_O:    rd_data = {7'b0, mmc_cmd_o};
      mmc_bb_pkg::REG_CMD_I:    rd_data = {7'b0, pins.cmd};
      mmc_bb_pkg::REG_OENS: begin
        rd_data = {3'b0, ident_q, 2'b0, mmc_data_oen_o, mmc_cmd_oen_o};
      end
      mmc_bb_pkg::REG_STATUS: begin
        rd_data = {3'b0, ctrl.trans_done, 2'b0, pins.wp, pins.cdetect};
      end
      mmc_bb_pkg::REG_ADV_TYPE: rd_data = {5'b0, adv_type_q};
      default:                  rd_data = '0;
    endcase
  end

  // Valid in the ack cycle
  always_ff @(posedge wb_clk_i) begin
    if (wb_acc) begin
      wb_dat_o <= rd_data;
    end
  end

  // ***************************************************************************
  // Advance decode and ack
  // ***************************************************************************
  always_comb begin
    case (adv_type_q)
      mmc_bb_pkg::ADV_CMD_RD: auto_adv = rd_acc && wb_adr_i == mmc_bb_pkg::REG_CMD_I;
      mmc_bb_pkg::ADV_CMD_WR: auto_adv = wr_acc && wb_adr_i == mmc_bb_pkg::REG_CMD_O;
      mmc_bb_pkg::ADV_DAT_RD: auto_adv = rd_acc && wb_adr_i == mmc_bb_pkg::REG_DAT_I;
      mmc_bb_pkg::ADV_DAT_WR: auto_adv = wr_acc && wb_adr_i == mmc_bb_pkg::REG_DAT_O;
      default:                auto_adv = 1'b0;
    endcase
  end

  // Manual advance works in every mode
  assign adv_req = (wr_acc && wb_adr_i == mmc_bb_pkg::REG_ADV_MAN) || auto_adv;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wb_ack_o <= 1'b0;
      adv_q    <= 1'b0;
    end else begin
      wb_ack_o <= wb_acc;
      adv_q    <= adv_req;
    end
  end

  assign ctrl.advance    = adv_q;
  assign ctrl.ident_mode = ident_q;

endmodule

`default_nettype wire

/* rtl/mmc_bb_clkgen.sv */
`default_nettype none

module mmc_bb_clkgen (
  input  wire         wb_clk_i,
  input  wire         wb_rst_i,
  mmc_bb_ctrl_if.gen  ctrl
);

  logic [mmc_bb_pkg::DATA_W-1:0] cnt_q;
  logic [mmc_bb_pkg::DATA_W-1:0] cnt_last;
  logic                          busy;

  // ***************************************************************************
  // Pulse counter
  // ***************************************************************************
  assign cnt_last = ctrl.ident_mode ? mmc_bb_pkg::IDENT_LAST : mmc_bb_pkg::FAST_LAST;
  assign busy     = (cnt_q != '0);

  // Advance while busy is dropped
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      cnt_q <= '0;
    end else if (busy) begin
      if (cnt_q == cnt_last) begin
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end else if (ctrl.advance) begin
      cnt_q <= 8'd1;
    end
  end

  // ***************************************************************************
  // Card clock
  // ***************************************************************************
  // High for the upper half of the count, one rising edge per pulse
  assign ctrl.card_clk   = ctrl.ident_mode ? cnt_q[mmc_bb_pkg::DATA_W-1] : cnt_q[1];
  assign ctrl.trans_done = ~busy;

endmodule

`default_nettype wire

/* rtl/mmc_bb.sv */
`default_nettype none

module mmc_bb (
  input  wire        wb_clk_i,
  input  wire        wb_rst_i,
  input  wire        wb_stb_i,
  input  wire        wb_cyc_i,
  input  wire        wb_we_i,
  input  wire  [2:0] wb_adr_i,
  input  wire  [7:0] wb_dat_i,
  output wire  [7:0] wb_dat_o,
  output wire        wb_ack_o,
  output wire        mmc_clk_o,
  output wire        mmc_cmd_o,
  output wire        mmc_cmd_oen_o,
  input  wire        mmc_cmd_i,
  output wire  [7:0] mmc_data_o,
  input  wire  [7:0] mmc_data_i,
  output wire        mmc_data_oen_o,
  input  wire        mmc_cdetect_i,
  input  wire        mmc_wp_i
);

  mmc_bb_pin_if  pin_bus ();
  mmc_bb_ctrl_if ctrl_bus ();

  // Stage 1: input pin synchronization
  mmc_bb_pin_sync pin_sync_i (
    .wb_clk_i      (wb_clk_i),
    .wb_rst_i      (wb_rst_i),
    .mmc_cmd_i     (mmc_cmd_i),
    .mmc_data_i    (mmc_data_i),
    .mmc_cdetect_i (mmc_cdetect_i),
    .mmc_wp_i      (mmc_wp_i),
    .pins          (pin_bus.sync)
  );

  // Stage 2: registers and advance decode
  mmc_bb_regs regs_i (
    .wb_clk_i       (wb_clk_i),
    .wb_rst_i       (wb_rst_i),
    .wb_stb_i       (wb_stb_i),
    .wb_cyc_i       (wb_cyc_i),
    .wb_we_i        (wb_we_i),
    .wb_adr_i       (wb_adr_i),
    .wb_dat_i       (wb_dat_i),
    .wb_dat_o       (wb_dat_o),
    .wb_ack_o       (wb_ack_o),
    .mmc_cmd_o      (mmc_cmd_o),
    .mmc_cmd_oen_o  (mmc_cmd_oen_o),
    .mmc_data_oen_o (mmc_data_oen_o),
    .mmc_data_o     (mmc_data_o),
    .pins           (pin_bus.regs),
    .ctrl           (ctrl_bus.dec)
  );

  // Stage 3: card clock pulse
  mmc_bb_clkgen clkgen_i (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .ctrl     (ctrl_bus.gen)
  );

  assign mmc_clk_o = ctrl_bus.card_clk;

endmodule

`default_nettype wire

/* verif/mmc_bb_asserts.sv */
`default_nettype none

module mmc_bb_asserts (
  input wire clk_i,
  input wire rst_i,
  input wire acc_i,
  input wire ack_i,
  input wire cmd_oen_i,
  input wire data_oen_i,
  input wire card_clk_i,
  input wire trans_done_i
);

  // Ack follows each access by exactly one cycle
  ack_after_access: assert property (@(posedge clk_i) disable iff (rst_i) acc_i |=> ack_i)
    else $error("Wishbone ack missing one cycle after an access");

  ack_only_after_access: assert property (
    @(posedge clk_i) disable iff (rst_i) ack_i |-> $past(acc_i))
    else $error("Wishbone ack without a preceding access");

  // Clock stays low in the first cycle of a pulse
  clk_only_when_busy: assert property (
    @(posedge clk_i) disable iff (rst_i) card_clk_i |-> !trans_done_i && $past(!trans_done_i))
    else $error("card clock high outside a pulse or in its first cycle");

  oen_clear_after_reset: assert property (
    @(posedge clk_i) $past(rst_i) && !rst_i |-> !cmd_oen_i && !data_oen_i)
    else $error("output enables not cleared after reset");

endmodule

bind mmc_bb mmc_bb_asserts chk_i (
  .clk_i (wb_clk_i), .rst_i (wb_rst_i), .acc_i (wb_stb_i & wb_cyc_i), .ack_i (wb_ack_o),
  .cmd_oen_i (mmc_cmd_oen_o), .data_oen_i (mmc_data_oen_o),
  .card_clk_i (mmc_clk_o), .trans_done_i (ctrl_bus.trans_done)
);

`default_nettype wire

/* verif/mmc_bb_tb.sv */
`default_nettype none

module mmc_bb_tb;

  logic       wb_clk_i;
  logic       wb_rst_i;
  logic       wb_stb_i;
  logic       wb_cyc_i;
  logic       wb_we_i;
  logic [2:0] wb_adr_i;
  logic [7:0] wb_dat_i;
  wire  [7:0] wb_dat_o;
  wire        wb_ack_o;
  wire        mmc_clk_o;
  wire        mmc_cmd_o;
  wire        mmc_cmd_oen_o;
  logic       mmc_cmd_i;
  wire  [7:0] mmc_data_o;
  logic [7:0] mmc_data_i;
  wire        mmc_data_oen_o;
  logic       mmc_cdetect_i;
  logic       mmc_wp_i;
  wire        pulse_idle;

  int         n_ops;
  int         busy_cnt;
  int         edge_cnt;
  logic       clk_prev;
  logic       ident_model;

  mmc_bb dut_i (
    .wb_clk_i       (wb_clk_i),
    .wb_rst_i       (wb_rst_i),
    .wb_stb_i       (wb_stb_i),
    .wb_cyc_i       (wb_cyc_i),
    .wb_we_i        (wb_we_i),
    .wb_adr_i       (wb_adr_i),
    .wb_dat_i       (wb_dat_i),
    .wb_dat_o       (wb_dat_o),
    .wb_ack_o       (wb_ack_o),
    .mmc_clk_o      (mmc_clk_o),
    .mmc_cmd_o      (mmc_cmd_o),
    .mmc_cmd_oen_o  (mmc_cmd_oen_o),
    .mmc_cmd_i      (mmc_cmd_i),
    .mmc_data_o     (mmc_data_o),
    .mmc_data_i     (mmc_data_i),
    .mmc_data_oen_o (mmc_data_oen_o),
    .mmc_cdetect_i  (mmc_cdetect_i),
    .mmc_wp_i       (mmc_wp_i)
  );

  assign pulse_idle = dut_i.ctrl_bus.trans_done;

  initial begin
    wb_clk_i = 1'b0;
    forever #2 wb_clk_i = ~wb_clk_i;
  end

  // Pulse monitor, sampled on the falling edge
  always @(negedge wb_clk_i) begin
    if (pulse_idle === 1'b0) begin
      busy_cnt = busy_cnt + 1;
    end
    if (mmc_clk_o === 1'b1 && clk_prev === 1'b0) begin
      edge_cnt = edge_cnt + 1;
    end
    clk_prev = mmc_clk_o;
  end

  // ***************************************************************************
  // Checks and bus tasks
  // ***************************************************************************
  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp_v,
                            input logic [7:0] act_v);
    assert (act_v === exp_v) else begin
      report_failure($sformatf("ERR %0s expected %02h actual %02h", name, exp_v, act_v));
    end
  endtask

  task automatic check_count(input string name, input int exp_v, input int act_v);
    assert (act_v == exp_v) else begin
      report_failure($sformatf("ERR %0s expected %0d actual %0d", name, exp_v, act_v));
    end
  endtask

  task automatic bus_access(input logic we, input logic [2:0] adr, input logic [7:0] dat,
                            output logic [7:0] rdat);
    int waited;
    @(posedge wb_clk_i);
    #1;
    wb_stb_i = 1'b1;
    wb_cyc_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = dat;
    @(posedge wb_clk_i);
    #1;
    wb_stb_i = 1'b0;
    wb_cyc_i = 1'b0;
    wb_we_i  = 1'b0;
    waited   = 0;
    while (wb_ack_o !== 1'b1 && waited < 1) begin
      @(posedge wb_clk_i);
      #1;
      waited = waited + 1;
    end
    assert (wb_ack_o === 1'b1) else begin
      report_failure("no Wishbone ack within 2 cycles of the access");
    end
    rdat = wb_dat_o;
  endtask

  task automatic wait_idle(input int limit);
    int n;
    n = 0;
    while (pulse_idle !== 1'b1 && n < limit) begin
      @(posedge wb_clk_i);
      #1;
      n = n + 1;
    end
    assert (pulse_idle === 1'b1) else begin
      report_failure("card clock pulse did not end in time");
    end
  endtask

  // ctl bits 2..0 address, bit 3 write, bit 4 second access during the pulse
  task automatic advance_check(input string name, input logic [7:0] ctl,
                               input logic [7:0] dat, input logic [7:0] exp_pulse);
    int         exp_len;
    int         exp_edges;
    logic [7:0] rd_v;
    wait_idle(int'(mmc_bb_pkg::IDENT_LAST) + 8);
    busy_cnt = 0;
    edge_cnt = 0;
    bus_access(ctl[3], ctl[2:0], dat, rd_v);
    if (ctl[4]) begin
      bus_access(ctl[3], ctl[2:0], dat, rd_v);
    end
    // A pulse starts 2 cycles after its access
    repeat (3) begin
      @(posedge wb_clk_i);
      #1;
    end
    wait_idle(int'(mmc_bb_pkg::IDENT_LAST) + 8);
    exp_len   = 0;
    exp_edges = 0;
    if (exp_pulse != 8'd0) begin
      exp_len   = ident_model ? int'(mmc_bb_pkg::IDENT_LAST) : int'(mmc_bb_pkg::FAST_LAST);
      exp_edges = 1;
    end
    check_count({name, "_busy"}, exp_len, busy_cnt);
    check_count({name, "_edges"}, exp_edges, edge_cnt);
  endtask

  // pins bit 0 cmd, bit 1 cdetect, bit 2 wp
  task automatic set_pins(input logic [7:0] pins, input logic [7:0] dat);
    @(posedge wb_clk_i);
    #1;
    mmc_cmd_i     = pins[0];
    mmc_cdetect_i = pins[1];
    mmc_wp_i      = pins[2];
    mmc_data_i    = dat;
    repeat (4) @(posedge wb_clk_i);
    #1;
  endtask

  task automatic run_op(input string op, input string name, input logic [7:0] a,
                        input logic [7:0] d, input logic [7:0] e);
    logic [7:0] rd_v;
    if (op == "W") begin
      bus_access(1'b1, a[2:0], d, rd_v);
      if (a[2:0] == mmc_bb_pkg::REG_OENS) begin
        ident_model = d[4];
      end
    end else if (op == "R") begin
      bus_access(1'b0, a[2:0], d, rd_v);
      check_byte(name, e, rd_v);
    end else if (op == "P") begin
      set_pins(a, d);
    end else if (op == "A") begin
      advance_check(name, a, d, e);
    end else if (op == "E") begin
      check_byte({name, "_ctl"}, a, {5'b0, mmc_data_oen_o, mmc_cmd_oen_o, mmc_cmd_o});
      check_byte({name, "_data"}, e, mmc_data_o);
    end else begin
      report_failure({"unknown opcode ", op, " in the trace file"});
    end
  endtask

  function automatic bit parse_line(input string line, output string op, output string name,
                                    output logic [7:0] a, output logic [7:0] d,
                                    output logic [7:0] e);
    int rc;
    rc = 0;
    if (line.len() > 0 && line.getc(0) != "#") begin
      rc = $sscanf(line, "%s %s %h %h %h", op, name, a, d, e);
    end
    return (rc == 5);
  endfunction

  // ***************************************************************************
  // Trace runner and watchdog
  // ***************************************************************************
  initial begin
    int         fd;
    string      line;
    string      op;
    string      name;
    logic [7:0] a_v;
    logic [7:0] d_v;
    logic [7:0] e_v;
    wb_rst_i      = 1'b1;
    wb_stb_i      = 1'b0;
    wb_cyc_i      = 1'b0;
    wb_we_i       = 1'b0;
    wb_adr_i      = 3'd0;
    wb_dat_i      = 8'h00;
    mmc_cmd_i     = 1'b0;
    mmc_data_i    = 8'h00;
    mmc_cdetect_i = 1'b0;
    mmc_wp_i      = 1'b0;
    busy_cnt      = 0;
    edge_cnt      = 0;
    clk_prev      = 1'b0;
    ident_model   = mmc_bb_pkg::RST_IDENT;
    n_ops         = 0;
    fd = $fopen("verif/mmc_bb_trace.txt", "r");
    assert (fd != 0) else report_failure("cannot open verif/mmc_bb_trace.txt");
    while ($fgets(line, fd) > 0) begin
      if (parse_line(line, op, name, a_v, d_v, e_v)) begin
        n_ops = n_ops + 1;
      end
    end
    $fclose(fd);
    fd = $fopen("verif/mmc_bb_trace.txt", "r");
    repeat (4) @(posedge wb_clk_i);
    #1;
    wb_rst_i = 1'b0;
    while ($fgets(line, fd) > 0) begin
      if (parse_line(line, op, name, a_v, d_v, e_v)) begin
        run_op(op, name, a_v, d_v, e_v);
      end
    end
    $fclose(fd);
    $display("test passed");
    $finish;
  end

  // 300 cycles of 4 time units per trace operation
  initial begin
    wait (n_ops > 0);
    #(n_ops * 1200);
    report_failure("watchdog expired before the trace finished");
  end

endmodule

`default_nettype wire

/* verif/mmc_bb_trace.txt */
# op name adr data expected, hex. P: adr = pins (b0 cmd, b1 cdetect, b2 wp), data = data pins
# A: adr b2..0 address, b3 write, b4 repeat, expected 1 = pulse. E: adr = {data_oen,cmd_oen,cmd}
R rst_dat_o    0  00 ff
R rst_cmd_o    2  00 01
R rst_oens     4  00 10
R rst_adv      6  00 00
R rst_status   5  00 10
E rst_pins     1  00 ff
W wr_dat_o     0  a5 00
W wr_cmd_o     2  fe 00
W wr_oens      4  03 00
R rb_dat_o     0  00 a5
R rb_oens      4  00 03
E wr_pins      6  00 a5
W wr_dat_i     1  00 00
W wr_cmd_i     3  01 00
W wr_status    5  ff 00
R ro_dat_o     0  00 a5
R ro_cmd_o     2  00 00
R ro_oens      4  00 03
R ro_adv       6  00 00
P pins_a       5  3c 00
R pin_dat_i    1  00 3c
R pin_cmd_i    3  00 01
R pin_status   5  00 12
A man_fast     0f 00 01
A man_repeat   1f 00 01
W adv_cmd_rd   6  01 00
A cmdrd_no     0a 00 00
A cmdrd_yes    03 00 01
W adv_cmd_wr   6  02 00
A cmdwr_no     03 00 00
A cmdwr_yes    0a 01 01
W adv_dat_rd   6  fb 00
R rb_adv       6  00 03
A datrd_no     08 5a 00
A datrd_yes    01 00 01
W adv_dat_wr   6  04 00
A datwr_no     01 00 00
A datwr_rpt    18 c3 01
W ident_on     4  13 00
A man_ident    0f 00 01
W adv_kick     7  00 00
R fill_dat_o   0  00 c3
R mid_status   5  00 02
E end_pins     7  00 c3

/* mmc_bb.f */
rtl/mmc_bb_pkg.sv
rtl/mmc_bb_pin_if.sv
rtl/mmc_bb_ctrl_if.sv
rtl/mmc_bb_pin_sync.sv
rtl/mmc_bb_regs.sv
rtl/mmc_bb_clkgen.sv
rtl/mmc_bb.sv
verif/mmc_bb_asserts.sv
verif/mmc_bb_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the mmc_bb testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module mmc_bb_tb -f mmc_bb.f \
  --Mdir obj_dir -o mmc_bb_sim \
  && ./obj_dir/mmc_bb_sim > sim.log 2>&1 \
  || echo "test failed" >> sim.log

cat sim.log
grep -q "test failed" sim.log && exit 1 || exit 0
